/* src.f */
+incdir+include
logic/xbar_bus_pkg.sv
logic/xbar_map_pkg.sv
logic/xbar_addr_decoder.sv
logic/xbar_target_arbiter.sv
logic/xbar_resp_router.sv
logic/xbar_node.sv
verif/xbar_node_chk.sv
verif/xbar_node_tb.sv

/* Makefile */
# Verilator build and run of the crossbar node testbench

SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := xbar_node_tb
FLIST    := src.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(filter-out +%,$(shell cat $(FLIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

# failure when the fail message shows up or the pass message is missing
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@! grep -q "Verification failed" $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verif/xbar_node_tb.sv */
// --------------------
// Crossbar node testbench
// --------------------

`timescale 1ns/10ps
`include "xbar_defs.svh"

module xbar_node_tb
   import xbar_bus_pkg::*;
   import xbar_map_pkg::*;
();

   localparam int NI          = `XBAR_N_INIT;
   localparam int NT          = `XBAR_N_TARG;
   localparam int DRIVE_DLY   = 1;     // ns after the rising edge
   localparam int TIMEOUT_CYC = 4000;  // 99 transfers, ~20 cycles each when stalled, doubled

   logic                    clk;
   logic                    rst_i;
   init_vec_t               slave_req_valid_i, slave_req_ready_o, slave_req_we_i;
   addr_t     [NI-1:0]      slave_req_addr_i;
   data_t     [NI-1:0]      slave_req_wdata_i;
   strb_t     [NI-1:0]      slave_req_strb_i;
   id_in_t    [NI-1:0]      slave_req_id_i;
   init_vec_t               slave_rsp_valid_o, slave_rsp_ready_i;
   data_t     [NI-1:0]      slave_rsp_rdata_o;
   resp_t     [NI-1:0]      slave_rsp_resp_o;
   id_in_t    [NI-1:0]      slave_rsp_id_o;
   targ_vec_t               master_req_valid_o, master_req_ready_i, master_req_we_o;
   addr_t     [NT-1:0]      master_req_addr_o;
   data_t     [NT-1:0]      master_req_wdata_o;
   strb_t     [NT-1:0]      master_req_strb_o;
   id_out_t   [NT-1:0]      master_req_id_o;
   targ_vec_t               master_rsp_valid_i, master_rsp_ready_o;
   data_t     [NT-1:0]      master_rsp_rdata_i;
   resp_t     [NT-1:0]      master_rsp_resp_i;
   id_out_t   [NT-1:0]      master_rsp_id_i;
   rule_addr_t              cfg_start_addr_i, cfg_end_addr_i;
   rule_en_t                cfg_rule_en_i;
   targ_vec_t [NI-1:0]      cfg_conn_map_i;

   // target models and scoreboard state
   data_t       mem [NT][1024];   // word memory per target
   logic [31:0] rng;
   logic        stall_en;         // random back-pressure on both sides
   targ_vec_t   pend;             // model holds an unsent response
   int          dly [NT];
   int          last_win [NT];    // last initiator granted per target
   id_out_t     exp_mid [NT];     // id expected at the master port
   int          sreq_cnt [NI];    // requests issued per initiator
   int          srsp_cnt [NI];
   int          mreq_cnt = 0;
   int          checks = 0;
   int          errors = 0;
   int          cycles = 0;

   xbar_node dut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic addr_t base_of(input int t);
      return addr_t'(32'h1000 * (t + 1));   // rule 0 start of target t
   endfunction

   function automatic int targ_of(input addr_t a);
      int t;
      t = -1;
      for (int k = 0; k < NT; k++) begin
         if (a >= base_of(k) && a <= base_of(k) + 32'hfff) t = k;
      end
      return t;
   endfunction

   task automatic compare_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   // --------------------
   // target models, master id check and round robin monitor
   always begin : target_models
      targ_vec_t mfire;
      targ_vec_t rfire;
      data_t     rd_n [NT];
      id_out_t   id_n [NT];
      int        w;
      int        win;
      logic      waiting;
      @(negedge clk);   // handshakes are stable here
      mfire = master_req_valid_o & master_req_ready_i;
      rfire = master_rsp_valid_i & master_rsp_ready_o;
      for (int t = 0; t < NT; t++) begin
         if (mfire[t]) begin
            mreq_cnt++;
            compare_word($sformatf("master_req_id_o[%0d]", t), 32'(master_req_id_o[t]),
                         32'(exp_mid[t]));
            w       = int'(master_req_addr_o[t][11:2]);
            rd_n[t] = master_req_we_o[t] ? '0 : mem[t][w];   // writes answer with zero
            id_n[t] = master_req_id_o[t];                      // echoed back
            for (int b = 0; b < 4; b++) begin
               if (master_req_we_o[t] && master_req_strb_o[t][b]) begin
                  mem[t][w][8*b +: 8] = master_req_wdata_o[t][8*b +: 8];
               end
            end
         end
         win     = -1;
         waiting = 1'b0;
         for (int i = 0; i < NI; i++) begin
            if (slave_req_valid_i[i] && targ_of(slave_req_addr_i[i]) == t &&
                cfg_conn_map_i[i][t]) begin
               if (slave_req_ready_o[i]) win = i;
               else waiting = 1'b1;
            end
         end
         if (win >= 0) begin
            checks++;
            assert (!(win == last_win[t] && waiting)) else begin
               $display("initiator %0d granted twice in a row at target %0d while another waited",
                        win, t);
               errors++;
            end
            last_win[t] = win;
            exp_mid[t]  = {init_sel_t'(win), slave_req_id_i[win]}; // index on top
         end
      end
      for (int i = 0; i < NI; i++) begin
         if (slave_rsp_valid_o[i] && slave_rsp_ready_i[i]) srsp_cnt[i]++;
      end
      @(posedge clk);
      #DRIVE_DLY;
      for (int t = 0; t < NT; t++) begin
         if (rst_i || rfire[t]) begin
            master_rsp_valid_i[t] = 1'b0;
            pend[t]               = 1'b0;
         end
         if (mfire[t]) begin
            rng                   = xorshift32(rng);
            pend[t]               = 1'b1;
            dly[t]                = int'(rng[9:8]);   // 0..3 extra cycles
            master_rsp_rdata_i[t] = rd_n[t];
            master_rsp_resp_i[t]  = `XBAR_RESP_OKAY;
            master_rsp_id_i[t]    = id_n[t];
         end
         if (pend[t] && !master_rsp_valid_i[t]) begin
            if (dly[t] == 0) master_rsp_valid_i[t] = 1'b1;
            else dly[t]--;
         end
         rng                   = xorshift32(rng);
         master_req_ready_i[t] = !pend[t] && (!stall_en || rng[12]);
      end
      for (int i = 0; i < NI; i++) begin
         rng                  = xorshift32(rng);
         slave_rsp_ready_i[i] = !stall_en || rng[12];
      end
   end

   // --------------------
   // initiator side
   task automatic xfer(input int i, input addr_t a, input logic we, input data_t wd,
                       input strb_t st, input id_in_t id, output data_t rd,
                       output resp_t rs, output id_in_t rid);
      @(posedge clk);
      #DRIVE_DLY;
      slave_req_valid_i[i] = 1'b1;
      slave_req_addr_i[i]  = a;
      slave_req_we_i[i]    = we;
      slave_req_wdata_i[i] = wd;
      slave_req_strb_i[i]  = st;
      slave_req_id_i[i]    = id;
      @(negedge clk);
      while (!slave_req_ready_o[i]) @(negedge clk);
      @(posedge clk);   // request taken on this edge
      #DRIVE_DLY;
      slave_req_valid_i[i] = 1'b0;
      sreq_cnt[i]++;
      @(negedge clk);
      while (!(slave_rsp_valid_o[i] && slave_rsp_ready_i[i])) @(negedge clk);
      rd  = slave_rsp_rdata_o[i];
      rs  = slave_rsp_resp_o[i];
      rid = slave_rsp_id_o[i];
   endtask

   task automatic xfer_check(input int i, input addr_t a, input logic we, input data_t wd,
                             input id_in_t id, input data_t exp_rd, input resp_t exp_rs,
                             input strb_t st = '1);
      data_t  rd;
      resp_t  rs;
      id_in_t rid;
      xfer(i, a, we, wd, st, id, rd, rs, rid);
      compare_word($sformatf("slave_rsp_rdata_o[%0d]", i), rd, exp_rd);
      compare_word($sformatf("slave_rsp_resp_o[%0d]", i), 32'(rs), 32'(exp_rs));
      compare_word($sformatf("slave_rsp_id_o[%0d]", i), 32'(rid), 32'(id));
   endtask

   // n writes then n reads of one initiator at one target
   task automatic stream(input int i, input int t, input int n, input data_t salt);
      addr_t a;
      for (int k = 0; k < n; k++) begin
         a = base_of(t) + addr_t'(32'h200 + 64 * i + 4 * k);
         xfer_check(i, a, 1'b1, {~a[15:0], a[15:0]} ^ salt, id_in_t'(k), '0, `XBAR_RESP_OKAY);
      end
      for (int k = 0; k < n; k++) begin
         a = base_of(t) + addr_t'(32'h200 + 64 * i + 4 * k);
         xfer_check(i, a, 1'b0, '0, id_in_t'(n - k), {~a[15:0], a[15:0]} ^ salt,
                    `XBAR_RESP_OKAY);
      end
   endtask

   // --------------------
   // directed tests
   task automatic write_then_read();
      addr_t a;
      data_t d;
      for (int i = 0; i < NI; i++) begin
         for (int t = 0; t < NT; t++) begin
            if (cfg_conn_map_i[i][t]) begin
               a = base_of(t) + addr_t'(16 * i);
               d = {8'hc0 + 8'(i), 8'h10 + 8'(t), a[15:0]};
               xfer_check(i, a, 1'b1, d, id_in_t'(4 * i + t), '0, `XBAR_RESP_OKAY);
               // bytes 0 and 2 overwritten with the inverse
               xfer_check(i, a, 1'b1, ~d, id_in_t'(8 + t), '0, `XBAR_RESP_OKAY,
                          strb_t'(4'b0101));
               d = (d & 32'hff00_ff00) | (~d & 32'h00ff_00ff);
               xfer_check(i, a, 1'b0, '0, id_in_t'(15 - t), d, `XBAR_RESP_OKAY);
            end
         end
      end
   endtask

   task automatic unmapped_address();
      int m0;
      m0 = mreq_cnt;
      xfer_check(0, 32'h0000_0800, 1'b1, 32'hdead_beef, 4'h3, '0, `XBAR_RESP_DECERR);
      xfer_check(1, 32'h0000_8010, 1'b0, '0, 4'h9, '0, `XBAR_RESP_DECERR); // disabled rule 1
      xfer_check(2, 32'h0000_5000, 1'b0, '0, 4'hc, '0, `XBAR_RESP_DECERR);
      compare_word("master request count", 32'(mreq_cnt), 32'(m0));
   endtask

   task automatic forbidden_pair();
      xfer_check(2, base_of(3) + 32'h20, 1'b1, 32'h1234_5678, 4'h5, '0, `XBAR_RESP_DECERR);
      xfer_check(0, base_of(3) + 32'h24, 1'b1, 32'h0bad_cafe, 4'h6, '0, `XBAR_RESP_OKAY);
      xfer_check(1, base_of(3) + 32'h24, 1'b0, '0, 4'h7, 32'h0bad_cafe, `XBAR_RESP_OKAY);
   endtask

   task automatic contention();
      fork
         stream(0, 1, 4, 32'h1111_0000);
         stream(1, 1, 4, 32'h2222_0000);
         stream(2, 1, 4, 32'h3333_0000);
      join
   endtask

   task automatic back_pressure();
      stall_en = 1'b1;
      fork
         stream(0, 3, 6, 32'h4444_0000);
         stream(1, 3, 6, 32'h5555_0000);
         stream(2, 0, 6, 32'h6666_0000);
      join
      stall_en = 1'b0;
      @(posedge clk);   // monitor has counted the last response by now
      for (int i = 0; i < NI; i++) begin
         compare_word($sformatf("response count of initiator %0d", i), 32'(srsp_cnt[i]),
                      32'(sreq_cnt[i]));
      end
   endtask

   // --------------------
   // main sequence
   initial begin
      rst_i              = 1'b1;
      slave_req_valid_i  = '0;
      slave_req_we_i     = '0;
      slave_req_addr_i   = '0;
      slave_req_wdata_i  = '0;
      slave_req_strb_i   = '0;
      slave_req_id_i     = '0;
      slave_rsp_ready_i  = '0;
      master_req_ready_i = '0;
      master_rsp_valid_i = '0;
      master_rsp_rdata_i = '0;
      master_rsp_resp_i  = '0;
      master_rsp_id_i    = '0;
      rng                = 32'h4913f697;
      stall_en           = 1'b0;
      pend               = '0;
      for (int t = 0; t < NT; t++) begin
         cfg_start_addr_i[0][t] = base_of(t);
         cfg_end_addr_i[0][t]   = base_of(t) + 32'hfff;
         cfg_start_addr_i[1][t] = base_of(t) + 32'h7000; // disabled window from 0x8000
         cfg_end_addr_i[1][t]   = base_of(t) + 32'h7fff;
         dly[t]                 = 0;
         last_win[t]            = -1;
         exp_mid[t]             = '0;
         for (int w = 0; w < 1024; w++) begin
            mem[t][w] = (base_of(t) + addr_t'(4 * w)) ^ 32'h6c6c_0000;
         end
      end
      cfg_rule_en_i[0]  = '1;
      cfg_rule_en_i[1]  = '0;
      cfg_conn_map_i[0] = 4'hf;
      cfg_conn_map_i[1] = 4'hf;
      cfg_conn_map_i[2] = 4'h7;   // initiator 2 may not reach target 3
      for (int i = 0; i < NI; i++) begin
         sreq_cnt[i] = 0;
         srsp_cnt[i] = 0;
      end
      repeat (3) @(posedge clk);
      #DRIVE_DLY;
      rst_i = 1'b0;
      write_then_read();
      unmapped_address();
      forbidden_pair();
      contention();
      back_pressure();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles == TIMEOUT_CYC) begin
         $display("timeout: tests still running after %0d cycles", TIMEOUT_CYC);
         $display("checks: %0d, errors: %0d", checks, errors + 1);
         $display("Verification failed");
         $finish;
      end
   end

endmodule

/* verif/xbar_node_chk.sv */
// --------------------
// Crossbar handshake checks
// --------------------

`timescale 1ns/10ps
`include "xbar_defs.svh"

module xbar_node_chk
   import xbar_bus_pkg::*;
   import xbar_map_pkg::*;
(
   input logic                         clk,
   input logic                         rst_i,
   input targ_vec_t                    m_valid_i,
   input targ_vec_t                    m_ready_i,
   input addr_t     [`XBAR_N_TARG-1:0] m_addr_i,
   input targ_vec_t                    m_we_i,
   input data_t     [`XBAR_N_TARG-1:0] m_wdata_i,
   input strb_t     [`XBAR_N_TARG-1:0] m_strb_i,
   input id_out_t   [`XBAR_N_TARG-1:0] m_id_i,
   input init_vec_t                    s_valid_i,
   input init_vec_t                    s_ready_i,
   input data_t     [`XBAR_N_INIT-1:0] s_rdata_i,
   input resp_t     [`XBAR_N_INIT-1:0] s_resp_i,
   input id_in_t    [`XBAR_N_INIT-1:0] s_id_i
);

   // registers are cleared by the first reset edge
   a_rst_quiet: assert property (@(posedge clk)
      $past(rst_i) |-> (m_valid_i == '0 && s_valid_i == '0))
      else $error("valid output high during reset");

   // --------------------
   // master request held until ready
   for (genvar t = 0; t < `XBAR_N_TARG; t++) begin : g_mreq
      a_mreq_hold: assert property (@(posedge clk) disable iff (rst_i)
         m_valid_i[t] && !m_ready_i[t] |=> m_valid_i[t] && $stable(m_addr_i[t]) &&
            $stable(m_we_i[t]) && $stable(m_wdata_i[t]) && $stable(m_strb_i[t]) &&
            $stable(m_id_i[t]))
         else $error("master request %0d changed while stalled", t);
   end

   // slave response held until ready
   for (genvar i = 0; i < `XBAR_N_INIT; i++) begin : g_srsp
      a_srsp_hold: assert property (@(posedge clk) disable iff (rst_i)
         s_valid_i[i] && !s_ready_i[i] |=> s_valid_i[i] && $stable(s_rdata_i[i]) &&
            $stable(s_resp_i[i]) && $stable(s_id_i[i]))
         else $error("slave response %0d changed while stalled", i);
   end

endmodule

bind xbar_node xbar_node_chk u_chk (
   .clk       (clk),
   .rst_i     (rst_i),
   .m_valid_i (master_req_valid_o),
   .m_ready_i (master_req_ready_i),
   .m_addr_i  (master_req_addr_o),
   .m_we_i    (master_req_we_o),
   .m_wdata_i (master_req_wdata_o),
   .m_strb_i  (master_req_strb_o),
   .m_id_i    (master_req_id_o),
   .s_valid_i (slave_rsp_valid_o),
   .s_ready_i (slave_rsp_ready_i),
   .s_rdata_i (slave_rsp_rdata_o),
   .s_resp_i  (slave_rsp_resp_o),
   .s_id_i    (slave_rsp_id_o)
);

/* logic/xbar_node.sv */
// --------------------
// Crossbar node top
// --------------------

`timescale 1ns/10ps
`include "xbar_defs.svh"

module xbar_node
   import xbar_bus_pkg::*;
   import xbar_map_pkg::*;
(
   input  logic                              clk,
   input  logic                              rst_i,
   // slave ports, one per initiator
   input  init_vec_t                         slave_req_valid_i,
   output init_vec_t                         slave_req_ready_o,
   input  addr_t     [`XBAR_N_INIT-1:0]      slave_req_addr_i,
   input  init_vec_t                         slave_req_we_i,
   input  data_t     [`XBAR_N_INIT-1:0]      slave_req_wdata_i,
   input  strb_t     [`XBAR_N_INIT-1:0]      slave_req_strb_i,
   input  id_in_t    [`XBAR_N_INIT-1:0]      slave_req_id_i,
   output init_vec_t                         slave_rsp_valid_o,
   input  init_vec_t                         slave_rsp_ready_i,
   output data_t     [`XBAR_N_INIT-1:0]      slave_rsp_rdata_o,
   output resp_t     [`XBAR_N_INIT-1:0]      slave_rsp_resp_o,
   output id_in_t    [`XBAR_N_INIT-1:0]      slave_rsp_id_o,
   // master ports, one per target
   output targ_vec_t                         master_req_valid_o,
   input  targ_vec_t                         master_req_ready_i,
   output addr_t     [`XBAR_N_TARG-1:0]      master_req_addr_o,
   output targ_vec_t                         master_req_we_o,
   output data_t     [`XBAR_N_TARG-1:0]      master_req_wdata_o,
   output strb_t     [`XBAR_N_TARG-1:0]      master_req_strb_o,
   output id_out_t   [`XBAR_N_TARG-1:0]      master_req_id_o,
   input  targ_vec_t                         master_rsp_valid_i,
   output targ_vec_t                         master_rsp_ready_o,
   input  data_t     [`XBAR_N_TARG-1:0]      master_rsp_rdata_i,
   input  resp_t     [`XBAR_N_TARG-1:0]      master_rsp_resp_i,
   input  id_out_t   [`XBAR_N_TARG-1:0]      master_rsp_id_i,
   // static memory map
   input  rule_addr_t                        cfg_start_addr_i,
   input  rule_addr_t                        cfg_end_addr_i,
   input  rule_en_t                          cfg_rule_en_i,
   input  targ_vec_t [`XBAR_N_INIT-1:0]      cfg_conn_map_i  // per initiator
);

   targ_vec_t [`XBAR_N_INIT-1:0] dec_req;    // [init][targ]
   targ_vec_t [`XBAR_N_INIT-1:0] dec_ready;  // [init][targ], grants seen by decoders
   init_vec_t [`XBAR_N_TARG-1:0] arb_req;    // [targ][init]
   init_vec_t [`XBAR_N_TARG-1:0] arb_grant;  // [targ][init]
   targ_vec_t [`XBAR_N_INIT-1:0] rtr_ready;  // each router's claim on target responses
   init_vec_t                    err_valid;
   id_in_t    [`XBAR_N_INIT-1:0] err_id;
   init_vec_t                    err_taken;

   // --------------------
   // request / grant transpose
   for (genvar i = 0; i < `XBAR_N_INIT; i++) begin : g_tr_init
      for (genvar t = 0; t < `XBAR_N_TARG; t++) begin : g_tr_targ
         assign arb_req[t][i]   = dec_req[i][t];
         assign dec_ready[i][t] = arb_grant[t][i];
      end
   end

   // at most one router claims a response, so OR is enough
   always_comb begin
      master_rsp_ready_o = '0;
      for (int i = 0; i < `XBAR_N_INIT; i++) begin
         master_rsp_ready_o |= rtr_ready[i];
      end
   end

   // --------------------
   // initiator side: decoders and response routers
   for (genvar i = 0; i < `XBAR_N_INIT; i++) begin : g_init
      xbar_addr_decoder u_dec (
         .clk          (clk),
         .rst_i        (rst_i),
         .req_valid_i  (slave_req_valid_i[i]),
         .req_ready_o  (slave_req_ready_o[i]),
         .req_addr_i   (slave_req_addr_i[i]),
         .req_id_i     (slave_req_id_i[i]),
         .start_addr_i (cfg_start_addr_i),
         .end_addr_i   (cfg_end_addr_i),
         .rule_en_i    (cfg_rule_en_i),
         .conn_map_i   (cfg_conn_map_i[i]),
         .targ_req_o   (dec_req[i]),
         .targ_ready_i (dec_ready[i]),
         .err_valid_o  (err_valid[i]),
         .err_id_o     (err_id[i]),
         .err_taken_i  (err_taken[i])
      );

      xbar_resp_router #(.INIT_IDX(i)) u_rtr (
         .clk         (clk),
         .rst_i       (rst_i),
         .t_valid_i   (master_rsp_valid_i),
         .t_ready_o   (rtr_ready[i]),
         .t_rdata_i   (master_rsp_rdata_i),
         .t_resp_i    (master_rsp_resp_i),
         .t_id_i      (master_rsp_id_i),
         .err_valid_i (err_valid[i]),
         .err_id_i    (err_id[i]),
         .err_taken_o (err_taken[i]),
         .s_valid_o   (slave_rsp_valid_o[i]),
         .s_ready_i   (slave_rsp_ready_i[i]),
         .s_rdata_o   (slave_rsp_rdata_o[i]),
         .s_resp_o    (slave_rsp_resp_o[i]),
         .s_id_o      (slave_rsp_id_o[i])
      );
   end

   // --------------------
   // target side arbiters
   for (genvar t = 0; t < `XBAR_N_TARG; t++) begin : g_targ
      xbar_target_arbiter #(.TARG_IDX(t)) u_arb (
         .clk         (clk),
         .rst_i       (rst_i),
         .req_i       (arb_req[t]),
         .grant_o     (arb_grant[t]),
         .req_addr_i  (slave_req_addr_i),
         .req_we_i    (slave_req_we_i),
         .req_wdata_i (slave_req_wdata_i),
         .req_strb_i  (slave_req_strb_i),
         .req_id_i    (slave_req_id_i),
         .m_valid_o   (master_req_valid_o[t]),
         .m_ready_i   (master_req_ready_i[t]),
         .m_addr_o    (master_req_addr_o[t]),
         .m_we_o      (master_req_we_o[t]),
         .m_wdata_o   (master_req_wdata_o[t]),
         .m_strb_o    (master_req_strb_o[t]),
         .m_id_o      (master_req_id_o[t])
      );
   end

endmodule

/* logic/xbar_resp_router.sv */
// --------------------
// Response router
// --------------------

`timescale 1ns/10ps
`include "xbar_defs.svh"

module xbar_resp_router
   import xbar_bus_pkg::*;
   import xbar_map_pkg::*;
#(
   parameter int INIT_IDX = 0
)(
   input  logic                          clk,
   input  logic                          rst_i,
   // responses from every target
   input  targ_vec_t                     t_valid_i,
   output targ_vec_t                     t_ready_o,   // only for responses this router owns
   input  data_t   [`XBAR_N_TARG-1:0]    t_rdata_i,
   input  resp_t   [`XBAR_N_TARG-1:0]    t_resp_i,
   input  id_out_t [`XBAR_N_TARG-1:0]    t_id_i,
   // local decode error from the decoder
   input  logic                          err_valid_i,
   input  id_in_t                        err_id_i,
   output logic                          err_taken_o,
   // slave response port
   output logic                          s_valid_o,
   input  logic                          s_ready_i,
   output data_t                         s_rdata_o,
   output resp_t                         s_resp_o,
   output id_in_t                        s_id_o
);

   localparam int TSEL_W = $clog2(`XBAR_N_TARG);

   logic              can_load;
   logic              own_found;  // some target holds a response for us
   logic [TSEL_W-1:0] own_idx;    // lowest such target
   logic              take_rsp;
   logic              full_q;
   data_t             rdata_q;
   resp_t             resp_q;
   id_in_t            id_q;

   // --------------------
   // claim by id high bits
   always_comb begin
      own_found = 1'b0;
      own_idx   = '0;
      for (int t = `XBAR_N_TARG-1; t >= 0; t--) begin // lowest target wins
         if (t_valid_i[t] &&
             t_id_i[t][`XBAR_ID_OUT_W-1 -: `XBAR_INIT_SEL_W] == init_sel_t'(INIT_IDX)) begin
            own_found = 1'b1;
            own_idx   = TSEL_W'(t);
         end
      end
   end

   assign can_load    = !full_q || s_ready_i;
   assign err_taken_o = err_valid_i && can_load;              // decerr goes first
   assign take_rsp    = !err_valid_i && can_load && own_found;
   assign t_ready_o   = take_rsp ? targ_vec_t'(1) << own_idx : '0;

   // --------------------
   // output register
   always_ff @(posedge clk) begin
      if (rst_i) begin
         full_q <= 1'b0;
      end else if (err_taken_o || take_rsp) begin
         full_q <= 1'b1;
      end else if (s_ready_i) begin
         full_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (err_taken_o) begin
         rdata_q <= '0;
         resp_q  <= `XBAR_RESP_DECERR;
         id_q    <= err_id_i;
      end else if (take_rsp) begin
         rdata_q <= t_rdata_i[own_idx];
         resp_q  <= t_resp_i[own_idx];
         id_q    <= t_id_i[own_idx][`XBAR_ID_IN_W-1:0]; // strip initiator bits
      end
   end

   assign s_valid_o = full_q;
   assign s_rdata_o = rdata_q;
   assign s_resp_o  = resp_q;
   assign s_id_o    = id_q;

endmodule

/* logic/xbar_target_arbiter.sv */
// --------------------
// Target arbiter
// --------------------

`timescale 1ns/10ps
`include "xbar_defs.svh"

module xbar_target_arbiter
   import xbar_bus_pkg::*;
   import xbar_map_pkg::*;
#(
   parameter int TARG_IDX = 0
)(
   input  logic                         clk,
   input  logic                         rst_i,
   // requests for this target, one bit per initiator
   input  init_vec_t                    req_i,
   output init_vec_t                    grant_o,
   // request fields of every initiator
   input  addr_t  [`XBAR_N_INIT-1:0]    req_addr_i,
   input  init_vec_t                    req_we_i,
   input  data_t  [`XBAR_N_INIT-1:0]    req_wdata_i,
   input  strb_t  [`XBAR_N_INIT-1:0]    req_strb_i,
   input  id_in_t [`XBAR_N_INIT-1:0]    req_id_i,
   // master port
   output logic                         m_valid_o,
   input  logic                         m_ready_i,
   output addr_t                        m_addr_o,
   output logic                         m_we_o,
   output data_t                        m_wdata_o,
   output strb_t                        m_strb_o,
   output id_out_t                      m_id_o
);

   init_sel_t ptr_q;      // initiator with top priority
   init_sel_t win_idx;
   logic      win_found;
   logic      can_load;   // output register empty or draining
   logic      full_q;
   addr_t     addr_q;
   logic      we_q;
   data_t     wdata_q;
   strb_t     strb_q;
   id_out_t   id_q;

   if (TARG_IDX >= `XBAR_N_TARG) begin : g_idx_range
      $error("xbar_target_arbiter: TARG_IDX out of range");
   end

   // --------------------
   // round robin pick, scanning from ptr_q upward
   always_comb begin
      int idx;
      idx       = 0;
      win_found = 1'b0;
      win_idx   = '0;
      for (int k = `XBAR_N_INIT-1; k >= 0; k--) begin // nearest to ptr_q is written last
         idx = (int'(ptr_q) + k) % `XBAR_N_INIT;
         if (req_i[idx]) begin
            win_found = 1'b1;
            win_idx   = init_sel_t'(idx);
         end
      end
   end

   assign can_load = !full_q || m_ready_i;
   assign grant_o  = (win_found && can_load) ? init_vec_t'(1) << win_idx : '0;

   // --------------------
   // one entry output register
   always_ff @(posedge clk) begin
      if (rst_i) begin
         full_q <= 1'b0;
         ptr_q  <= '0;
      end else if (|grant_o) begin
         full_q <= 1'b1;
         // winner drops to lowest priority
         ptr_q  <= (win_idx == init_sel_t'(`XBAR_N_INIT-1)) ? '0 : win_idx + 1'b1;
      end else if (m_ready_i) begin
         full_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (|grant_o) begin
         addr_q  <= req_addr_i[win_idx];
         we_q    <= req_we_i[win_idx];
         wdata_q <= req_wdata_i[win_idx];
         strb_q  <= req_strb_i[win_idx];
         id_q    <= {win_idx, req_id_i[win_idx]}; // initiator index on top
      end
   end

   assign m_valid_o = full_q;
   assign m_addr_o  = addr_q;
   assign m_we_o    = we_q;
   assign m_wdata_o = wdata_q;
   assign m_strb_o  = strb_q;
   assign m_id_o    = id_q;

endmodule

/* logic/xbar_addr_decoder.sv */
// --------------------
// Address decoder
// --------------------

`timescale 1ns/10ps
`include "xbar_defs.svh"

module xbar_addr_decoder
   import xbar_bus_pkg::*;
   import xbar_map_pkg::*;
(
   input  logic       clk,
   input  logic       rst_i,
   // initiator request, only the fields the decode needs
   input  logic       req_valid_i,
   output logic       req_ready_o,
   input  addr_t      req_addr_i,
   input  id_in_t     req_id_i,
   // static memory map
   input  rule_addr_t start_addr_i,
   input  rule_addr_t end_addr_i,
   input  rule_en_t   rule_en_i,
   input  targ_vec_t  conn_map_i,   // targets this initiator may reach
   // towards the target arbiters
   output targ_vec_t  targ_req_o,   // one-hot
   input  targ_vec_t  targ_ready_i, // grant for this initiator, per target
   // decode error towards the response router
   output logic       err_valid_o,
   output id_in_t     err_id_o,
   input  logic       err_taken_i
);

   targ_vec_t hit;        // targets with a matching enabled rule
   targ_vec_t allowed;    // hits the connectivity map lets through
   targ_vec_t sel;        // lowest allowed target, one-hot
   logic      dec_err;    // request with nowhere to go
   logic      err_pend_q;
   id_in_t    err_id_q;

   // --------------------
   // region match
   always_comb begin
      hit = '0;
      for (int t = 0; t < `XBAR_N_TARG; t++) begin
         for (int r = 0; r < `XBAR_N_REGION; r++) begin
            if (rule_en_i[r][t] &&
                req_addr_i >= start_addr_i[r][t] &&
                req_addr_i <= end_addr_i[r][t]) begin
               hit[t] = 1'b1; // inclusive on both ends
            end
         end
      end
   end

   assign allowed = hit & conn_map_i;
   assign sel     = allowed & (~allowed + targ_vec_t'(1)); // keep lowest set bit only

   // --------------------
   // routed requests pass straight through
   assign targ_req_o  = (req_valid_i && !err_pend_q) ? sel : '0;
   assign dec_err     = req_valid_i && !err_pend_q && (allowed == '0);
   assign req_ready_o = dec_err || (|(targ_req_o & targ_ready_i)); // error is swallowed here

   // pending decode error, blocks the port until the router takes it
   always_ff @(posedge clk) begin
      if (rst_i) begin
         err_pend_q <= 1'b0;
      end else if (dec_err) begin
         err_pend_q <= 1'b1;
      end else if (err_taken_i) begin
         err_pend_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (dec_err) begin
         err_id_q <= req_id_i; // echoed back with the decerr
      end
   end

   assign err_valid_o = err_pend_q;
   assign err_id_o    = err_id_q;

endmodule

/* logic/xbar_map_pkg.sv */
// --------------------
// Crossbar memory map
// --------------------

`include "xbar_defs.svh"

package xbar_map_pkg;

   // port selects
   typedef logic [`XBAR_INIT_SEL_W-1:0] init_sel_t;  // initiator index
   typedef logic [`XBAR_N_TARG-1:0]     targ_vec_t;  // one bit per target
   typedef logic [`XBAR_N_INIT-1:0]     init_vec_t;  // one bit per initiator

   // --------------------
   // rule table, indexed [region][target]
   typedef logic [`XBAR_N_REGION-1:0][`XBAR_N_TARG-1:0][`XBAR_ADDR_W-1:0] rule_addr_t;
   typedef logic [`XBAR_N_REGION-1:0][`XBAR_N_TARG-1:0]                   rule_en_t;

   // start and end are both inclusive bounds

endpackage

/* logic/xbar_bus_pkg.sv */
// --------------------
// Crossbar bus fields
// --------------------

`include "xbar_defs.svh"

package xbar_bus_pkg;

   // --------------------
   // request channel fields
   typedef logic [`XBAR_ADDR_W-1:0]   addr_t;  // byte address
   typedef logic [`XBAR_DATA_W-1:0]   data_t;  // write or read data word
   typedef logic [`XBAR_DATA_W/8-1:0] strb_t;  // one strobe per data byte

   // id as seen by an initiator
   typedef logic [`XBAR_ID_IN_W-1:0]  id_in_t;

   // id as seen by a target
   // upper INIT_SEL_W bits carry the issuing initiator, lower bits the original id
   typedef logic [`XBAR_ID_OUT_W-1:0] id_out_t;

   // --------------------
   // response channel fields
   typedef logic [1:0]                resp_t;  // okay / decerr

   // rdata reuses data_t, id uses id_in_t or id_out_t depending on side

endpackage

/* include/xbar_defs.svh */
// --------------------
// Crossbar node sizes
// --------------------

`ifndef XBAR_DEFS_SVH
`define XBAR_DEFS_SVH

// port counts
`define XBAR_N_INIT      3  // initiator (slave) ports
`define XBAR_N_TARG      4  // target (master) ports
`define XBAR_N_REGION    2  // address rules per target

// field widths
`define XBAR_ADDR_W      32
`define XBAR_DATA_W      32
`define XBAR_ID_IN_W     4
`define XBAR_INIT_SEL_W  2  // enough bits to name any initiator
`define XBAR_ID_OUT_W    (`XBAR_ID_IN_W + `XBAR_INIT_SEL_W)

// response codes, same encoding as axi resp
`define XBAR_RESP_OKAY   2'b00
`define XBAR_RESP_DECERR 2'b11

`endif
